/* run_sim.sh */
#!/bin/sh
# build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_ppu \
    --Mdir "$BUILD" -o tb_ppu_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD/tb_ppu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* sources.f */
src/ppu_pkg.sv
src/ppu_raster_timer.sv
src/ppu_register_file.sv
src/ppu_palette_ram.sv
src/ppu_vram_sequencer.sv
src/ppu_top.sv
verification/tb_ppu.sv

/* src/ppu_palette_ram.sv */
// PPU palette memory
// 32 bytes with a synchronous write and a combinational read

`timescale 1ns/10ps
`default_nettype none

module ppu_palette_ram (
    input  wire        i_clk,
    input  wire        i_we,
    input  wire  [4:0] i_index,
    input  wire  [7:0] i_wdata,
    output logic [7:0] o_rdata
);

    logic [7:0] mem [ppu_pkg::PALETTE_ENTRIES];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_index] <= i_wdata;
        end
    end

    // read follows the index within the same cycle
    assign o_rdata = mem[i_index];

endmodule

`default_nettype wire

/* src/ppu_pkg.sv */
// PPU shared definitions
// register select codes, CPU and VRAM bus structs, control layout, address constants

`default_nettype none

package ppu_pkg;

    // raster counters are this wide for both x and y
    localparam int DOT_W = 9;

    // PPUDATA steps by one byte or by a full nametable row
    localparam int ADDR_INC_ROW = 32;

    // palette lives at the top of the PPU map
    localparam int PALETTE_ENTRIES = 32;

    typedef logic [15:0] vram_addr_t;

    localparam vram_addr_t PALETTE_BASE = 16'h3F00;

    // CPU register select in the chip's own order
    typedef enum logic [2:0]
    {
        RS_PPUCTRL   = 3'd0,
        RS_PPUMASK   = 3'd1,
        RS_PPUSTATUS = 3'd2,
        RS_OAMADDR   = 3'd3,
        RS_OAMDATA   = 3'd4,
        RS_PPUSCROLL = 3'd5,
        RS_PPUADDR   = 3'd6,
        RS_PPUDATA   = 3'd7
    } rs_t;

    // one CPU access that is valid while cs_n is low
    typedef struct packed
    {
        logic       cs_n;
        logic       rw;         // 1 = read, 0 = write
        rs_t        rs;
        logic [7:0] data;
    } cpu_req_t;

    // PPUCTRL bit layout
    typedef struct packed
    {
        logic       nmi_enable; // bit 7 raises the interrupt in vblank
        logic [3:0] unused;     // pattern and sprite selects unused by this core
        logic       addr_inc32; // bit 2 selects a PPUDATA step of 32
        logic [1:0] nametable;  // base nametable select
    } ppu_ctrl_t;

    // outgoing VRAM bus with active low strobes
    typedef struct packed
    {
        logic        rd_n;
        logic        we_n;
        logic [13:0] addr;
        logic [7:0]  data;
    } vram_bus_t;

    // current raster position
    typedef struct packed
    {
        logic [DOT_W-1:0] x;
        logic [DOT_W-1:0] y;
        logic             visible;
    } raster_pos_t;

endpackage

`default_nettype wire

/* src/ppu_raster_timer.sv */
// PPU raster timer
// dot and scanline counters with the visible flag and the vblank edge pulses

`timescale 1ns/10ps
`default_nettype none

module ppu_raster_timer #(
    parameter int P_DOTS_PER_LINE   = 341,
    parameter int P_LINES_PER_FRAME = 262,
    parameter int P_VISIBLE_DOTS    = 256,
    parameter int P_VISIBLE_LINES   = 240,
    parameter int P_VBLANK_LINE     = 241
) (
    input  wire                  i_clk,
    input  wire                  i_reset_n,
    output ppu_pkg::raster_pos_t o_pos,
    output logic                 o_vblank_set,
    output logic                 o_vblank_clr
);

    typedef logic [ppu_pkg::DOT_W-1:0] dot_t;

    localparam dot_t X_LAST      = dot_t'(P_DOTS_PER_LINE - 1);
    localparam dot_t Y_LAST      = dot_t'(P_LINES_PER_FRAME - 1);
    localparam dot_t X_VISIBLE   = dot_t'(P_VISIBLE_DOTS);
    localparam dot_t Y_VISIBLE   = dot_t'(P_VISIBLE_LINES);
    localparam dot_t VBLANK_LINE = dot_t'(P_VBLANK_LINE);

    dot_t x_q;
    dot_t y_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            x_q <= '0;
            y_q <= '0;
        end
        else if (x_q == X_LAST)
        begin
            x_q <= '0;
            y_q <= (y_q == Y_LAST) ? '0 : y_q + dot_t'(1); // end of frame wraps to line 0
        end
        else
        begin
            x_q <= x_q + dot_t'(1);
        end
    end

    assign o_pos.x       = x_q;
    assign o_pos.y       = y_q;
    assign o_pos.visible = (x_q < X_VISIBLE) && (y_q < Y_VISIBLE);

    // edges are seen at dot 0 and the flag register picks them up next cycle
    assign o_vblank_set = (x_q == '0) && (y_q == VBLANK_LINE);
    assign o_vblank_clr = (x_q == '0) && (y_q == Y_LAST);

endmodule

`default_nettype wire

/* src/ppu_register_file.sv */
// PPU CPU register file
// PPUCTRL, PPUSTATUS, PPUADDR and PPUDATA decode with the vblank flag

`timescale 1ns/10ps
`default_nettype none

module ppu_register_file (
    input  wire               i_clk,
    input  wire               i_reset_n,
    input  ppu_pkg::cpu_req_t i_cpu,
    input  wire               i_vblank_set,
    input  wire               i_vblank_clr,
    input  wire  [7:0]        i_palette_rdata,
    input  wire  [7:0]        i_read_buffer,
    output logic [7:0]        o_data,
    output logic              o_int_n,
    output logic              o_palette_we,
    output logic [4:0]        o_palette_index,
    output logic [7:0]        o_palette_wdata,
    output logic              o_vram_wr_start,
    output logic              o_vram_rd_start,
    output logic [13:0]       o_vram_addr,
    output logic [7:0]        o_vram_wdata
);

    ppu_pkg::ppu_ctrl_t  ctrl_q;
    ppu_pkg::vram_addr_t ppu_addr_q;
    logic                toggle_q;      // 0 = next PPUADDR write is the high byte
    logic                vblank_q;

    logic                cpu_rd;
    logic                cpu_wr;
    logic                status_rd;
    logic                data_access;
    logic                in_palette;
    ppu_pkg::vram_addr_t addr_step;

    assign cpu_rd      = !i_cpu.cs_n && i_cpu.rw;
    assign cpu_wr      = !i_cpu.cs_n && !i_cpu.rw;
    assign status_rd   = cpu_rd && (i_cpu.rs == ppu_pkg::RS_PPUSTATUS);
    assign data_access = !i_cpu.cs_n && (i_cpu.rs == ppu_pkg::RS_PPUDATA);

    // 3F00 to 3FFF is palette and everything above is left alone
    assign in_palette = (ppu_addr_q[15:8] == ppu_pkg::PALETTE_BASE[15:8]);

    assign addr_step = ctrl_q.addr_inc32 ? ppu_pkg::vram_addr_t'(ppu_pkg::ADDR_INC_ROW)
                                         : ppu_pkg::vram_addr_t'(1);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ctrl_q     <= '0;
            ppu_addr_q <= '0;
            toggle_q   <= 1'b0;
        end
        else
        begin
            if (cpu_wr && (i_cpu.rs == ppu_pkg::RS_PPUCTRL))
            begin
                ctrl_q <= ppu_pkg::ppu_ctrl_t'(i_cpu.data);
            end

            if (cpu_wr && (i_cpu.rs == ppu_pkg::RS_PPUADDR))
            begin
                if (!toggle_q)
                    ppu_addr_q[15:8] <= i_cpu.data;
                else
                    ppu_addr_q[7:0] <= i_cpu.data;
            end
            else if (data_access)
            begin
                ppu_addr_q <= ppu_addr_q + addr_step;  // step after every data access
            end

            if (status_rd)
                toggle_q <= 1'b0;
            else if (cpu_wr && (i_cpu.rs == ppu_pkg::RS_PPUADDR))
                toggle_q <= !toggle_q;
        end
    end

    // a status read wins over both raster edges
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            vblank_q <= 1'b0;
        else if (status_rd)
            vblank_q <= 1'b0;
        else if (i_vblank_set)
            vblank_q <= 1'b1;
        else if (i_vblank_clr)
            vblank_q <= 1'b0;
    end

    assign o_int_n = !(vblank_q && ctrl_q.nmi_enable);

    always_comb
    begin
        o_data = '0;
        if (cpu_rd)
        begin
            case (i_cpu.rs)
                ppu_pkg::RS_PPUSTATUS: o_data = {vblank_q, 7'b0};   // low bits read zero
                ppu_pkg::RS_PPUDATA:   o_data = in_palette ? i_palette_rdata : i_read_buffer;
                default:               o_data = '0;
            endcase
        end
    end

    // direct palette write port
    assign o_palette_we    = data_access && !i_cpu.rw && in_palette;
    assign o_palette_index = ppu_addr_q[4:0];
    assign o_palette_wdata = i_cpu.data;

    // the sequencer latches VRAM address and data with the start strobe
    assign o_vram_wr_start = data_access && !i_cpu.rw && (ppu_addr_q < ppu_pkg::PALETTE_BASE);
    assign o_vram_rd_start = data_access && i_cpu.rw;
    assign o_vram_addr     = ppu_addr_q[13:0];
    assign o_vram_wdata    = i_cpu.data;

endmodule

`default_nettype wire

/* src/ppu_top.sv */
// PPU core top level
// CPU register port, VRAM bus and raster position output

`timescale 1ns/10ps
`default_nettype none

module ppu_top #(
    parameter int P_DOTS_PER_LINE   = 341,
    parameter int P_LINES_PER_FRAME = 262,
    parameter int P_VISIBLE_DOTS    = 256,
    parameter int P_VISIBLE_LINES   = 240,
    parameter int P_VBLANK_LINE     = 241
) (
    input  wire                  i_clk,
    input  wire                  i_reset_n,
    input  ppu_pkg::cpu_req_t    i_cpu,
    input  wire  [7:0]           i_vram_data,
    output logic [7:0]           o_data,
    output logic                 o_int_n,
    output ppu_pkg::vram_bus_t   o_vram,
    output ppu_pkg::raster_pos_t o_video
);

    logic        vblank_set;
    logic        vblank_clr;
    logic        palette_we;
    logic [4:0]  palette_index;
    logic [7:0]  palette_wdata;
    logic [7:0]  palette_rdata;
    logic        vram_wr_start;
    logic        vram_rd_start;
    logic [13:0] vram_addr;
    logic [7:0]  vram_wdata;
    logic [7:0]  read_buffer;

    ppu_raster_timer #(
        .P_DOTS_PER_LINE   (P_DOTS_PER_LINE),
        .P_LINES_PER_FRAME (P_LINES_PER_FRAME),
        .P_VISIBLE_DOTS    (P_VISIBLE_DOTS),
        .P_VISIBLE_LINES   (P_VISIBLE_LINES),
        .P_VBLANK_LINE     (P_VBLANK_LINE)
    ) u_raster_timer (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .o_pos        (o_video),
        .o_vblank_set (vblank_set),
        .o_vblank_clr (vblank_clr)
    );

    ppu_register_file u_register_file (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cpu           (i_cpu),
        .i_vblank_set    (vblank_set),
        .i_vblank_clr    (vblank_clr),
        .i_palette_rdata (palette_rdata),
        .i_read_buffer   (read_buffer),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_palette_we    (palette_we),
        .o_palette_index (palette_index),
        .o_palette_wdata (palette_wdata),
        .o_vram_wr_start (vram_wr_start),
        .o_vram_rd_start (vram_rd_start),
        .o_vram_addr     (vram_addr),
        .o_vram_wdata    (vram_wdata)
    );

    ppu_palette_ram u_palette_ram (
        .i_clk   (i_clk),
        .i_we    (palette_we),
        .i_index (palette_index),
        .i_wdata (palette_wdata),
        .o_rdata (palette_rdata)
    );

    ppu_vram_sequencer u_vram_sequencer (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_wr_start    (vram_wr_start),
        .i_rd_start    (vram_rd_start),
        .i_addr        (vram_addr),
        .i_wdata       (vram_wdata),
        .i_vram_rdata  (i_vram_data),
        .o_vram        (o_vram),
        .o_read_buffer (read_buffer)
    );

endmodule

`default_nettype wire

/* src/ppu_vram_sequencer.sv */
// PPU VRAM access sequencer
// turns start strobes into one-cycle read or write strobes and keeps the read buffer

`timescale 1ns/10ps
`default_nettype none

module ppu_vram_sequencer (
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire                 i_wr_start,
    input  wire                 i_rd_start,
    input  wire  [13:0]         i_addr,
    input  wire  [7:0]          i_wdata,
    input  wire  [7:0]          i_vram_rdata,
    output ppu_pkg::vram_bus_t  o_vram,
    output logic [7:0]          o_read_buffer
);

    typedef enum logic [1:0]
    {
        ST_IDLE      = 2'd0,
        ST_WR_STROBE = 2'd1,
        ST_RD_STROBE = 2'd2
    } seq_state_t;

    seq_state_t  state_q;
    logic [13:0] addr_q;
    logic [7:0]  wdata_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state_q       <= ST_IDLE;
            o_read_buffer <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (i_wr_start)
                        state_q <= ST_WR_STROBE;
                    else if (i_rd_start)
                        state_q <= ST_RD_STROBE;
                end
                ST_RD_STROBE:
                begin
                    o_read_buffer <= i_vram_rdata;  // byte returned on the next PPUDATA read
                    state_q       <= ST_IDLE;
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // payload follows the strobe that starts the access
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            addr_q  <= '0;
            wdata_q <= '0;
        end
        else if ((state_q == ST_IDLE) && (i_wr_start || i_rd_start))
        begin
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
        end
    end

    assign o_vram.rd_n = (state_q != ST_RD_STROBE);
    assign o_vram.we_n = (state_q != ST_WR_STROBE);
    assign o_vram.addr = addr_q;
    assign o_vram.data = (state_q == ST_WR_STROBE) ? wdata_q : '0;   // bus idle at zero

endmodule

`default_nettype wire

/* verification/tb_ppu.sv */
// PPU core testbench
// random CPU traffic against a behavioral VRAM and a reference model of the register port

`timescale 1ns/10ps
`default_nettype none

module tb_ppu;

    localparam logic [8:0] DOT_LAST  = 9'd340;
    localparam logic [8:0] LINE_LAST = 9'd261;
    localparam logic [8:0] VIS_X     = 9'd256;
    localparam logic [8:0] VIS_Y     = 9'd240;
    localparam logic [8:0] VBL_LINE  = 9'd241;
    localparam int         FRAME     = 341 * 262;
    localparam int         MEM_SZ    = 16384;

    logic                 clk;
    logic                 reset_n;
    ppu_pkg::cpu_req_t    cpu;
    logic [7:0]           vram_rdata;
    logic [7:0]           cpu_data;
    logic                 int_n;
    ppu_pkg::vram_bus_t   vram_bus;
    ppu_pkg::raster_pos_t video;

    logic [7:0]  vram_mem [MEM_SZ];     // VRAM as seen on the DUT bus
    logic [31:0] lfsr = 32'h563c4a65;
    logic        checking = 1'b0;
    logic        timed_out = 1'b0;
    int          flow_errors = 0;
    int          mon_errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // reference model state
    logic [8:0]  mx;
    logic [8:0]  my;
    logic        m_vbl;
    logic [7:0]  m_ctrl;
    logic [15:0] m_addr;
    logic        m_tog;
    logic [7:0]  m_buf;
    logic [7:0]  m_pal [32];
    logic [7:0]  m_vram [MEM_SZ];
    logic        exp_wr;                // strobe expected in the current cycle
    logic        exp_rd;
    logic [13:0] exp_addr;
    logic [7:0]  exp_data;
    logic        model_status_rd;

    ppu_top dut (
        .i_clk       (clk),
        .i_reset_n   (reset_n),
        .i_cpu       (cpu),
        .i_vram_data (vram_rdata),
        .o_data      (cpu_data),
        .o_int_n     (int_n),
        .o_vram      (vram_bus),
        .o_video     (video)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] fill_byte(input logic [13:0] a);
        return a[7:0] ^ {2'b01, a[13:8]};
    endfunction

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < width; i++)
        begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic bit value_ok(input string name, input logic [15:0] got,
                                    input logic [15:0] exp);
        assert (got === exp)
        else $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        return got === exp;
    endfunction

    assign vram_rdata = vram_bus.rd_n ? 8'h00 : vram_mem[vram_bus.addr];

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < MEM_SZ; i++)
                vram_mem[i] <= fill_byte(14'(i));
        end
        else if (vram_bus.we_n === 1'b0)
            vram_mem[vram_bus.addr] <= vram_bus.data;
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            mx       = '0;
            my       = '0;
            m_vbl    = 1'b0;
            m_ctrl   = '0;
            m_addr   = '0;
            m_tog    = 1'b0;
            m_buf    = '0;
            exp_wr   = 1'b0;
            exp_rd   = 1'b0;
            exp_addr = '0;
            exp_data = '0;
            for (int i = 0; i < MEM_SZ; i++)
                m_vram[i] = fill_byte(14'(i));
        end
        else
        begin
            if (exp_rd)
                m_buf = m_vram[exp_addr];   // strobe cycle just ended
            if (exp_wr)
                m_vram[exp_addr] = exp_data;
            exp_rd = 1'b0;
            exp_wr = 1'b0;
            model_status_rd = !cpu.cs_n && cpu.rw && (cpu.rs == ppu_pkg::RS_PPUSTATUS);
            if (model_status_rd)
                m_vbl = 1'b0;
            else if (mx == 9'd0 && my == VBL_LINE)
                m_vbl = 1'b1;
            else if (mx == 9'd0 && my == LINE_LAST)
                m_vbl = 1'b0;
            if (model_status_rd)
                m_tog = 1'b0;
            if (!cpu.cs_n && !cpu.rw && cpu.rs == ppu_pkg::RS_PPUCTRL)
                m_ctrl = cpu.data;
            if (!cpu.cs_n && !cpu.rw && cpu.rs == ppu_pkg::RS_PPUADDR)
            begin
                if (!m_tog)
                    m_addr[15:8] = cpu.data;
                else
                    m_addr[7:0] = cpu.data;
                m_tog = !m_tog;
            end
            if (!cpu.cs_n && cpu.rs == ppu_pkg::RS_PPUDATA)
            begin
                exp_addr = m_addr[13:0];
                exp_data = cpu.data;
                exp_rd   = cpu.rw;
                exp_wr   = !cpu.rw && (m_addr < 16'h3f00);
                if (!cpu.rw && m_addr[15:8] == 8'h3f)
                    m_pal[m_addr[4:0]] = cpu.data;
                m_addr = m_addr + (m_ctrl[2] ? 16'd32 : 16'd1);
            end
            if (mx == DOT_LAST)
            begin
                mx = 9'd0;
                my = (my == LINE_LAST) ? 9'd0 : my + 9'd1;
            end
            else
                mx = mx + 9'd1;
        end
    end

    function automatic logic [7:0] expected_read();
        if (cpu.rs == ppu_pkg::RS_PPUSTATUS)
            return {m_vbl, 7'b0};
        if (cpu.rs == ppu_pkg::RS_PPUDATA)
            return (m_addr[15:8] == 8'h3f) ? m_pal[m_addr[4:0]] : m_buf;
        return 8'h00;
    endfunction

    // outputs against the model every cycle in the middle of the clock low phase
    always @(negedge clk)
    begin
        if (checking)
        begin
            if (!value_ok("o_video.x", 16'(video.x), 16'(mx)))
                mon_errors++;
            if (!value_ok("o_video.y", 16'(video.y), 16'(my)))
                mon_errors++;
            if (!value_ok("o_video.visible", 16'(video.visible), 16'(mx < VIS_X && my < VIS_Y)))
                mon_errors++;
            if (!value_ok("o_int_n", 16'(int_n), 16'(!(m_vbl && m_ctrl[7]))))
                mon_errors++;
            if (!value_ok("o_vram.we_n", 16'(vram_bus.we_n), 16'(!exp_wr)))
                mon_errors++;
            if (!value_ok("o_vram.rd_n", 16'(vram_bus.rd_n), 16'(!exp_rd)))
                mon_errors++;
            if (!value_ok("o_vram.data", 16'(vram_bus.data), exp_wr ? 16'(exp_data) : 16'h0))
                mon_errors++;
            if ((exp_wr || exp_rd) && !value_ok("o_vram.addr", 16'(vram_bus.addr), 16'(exp_addr)))
                mon_errors++;
            if (!cpu.cs_n && cpu.rw && !value_ok("o_data", 16'(cpu_data), 16'(expected_read())))
                mon_errors++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;                                 // inputs change just after the edge
    endtask

    task automatic pause(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic cpu_write(input ppu_pkg::rs_t rs, input logic [7:0] data);
        cpu = {1'b0, 1'b0, rs, data};
        next_cycle();
        cpu.cs_n = 1'b1;
    endtask

    task automatic cpu_read(input ppu_pkg::rs_t rs, output logic [7:0] data);
        cpu = {1'b0, 1'b1, rs, 8'h00};
        @(negedge clk);
        data = cpu_data;
        next_cycle();
        cpu.cs_n = 1'b1;
    endtask

    task automatic report_timeout(input string why);
        $display("error: timed out waiting for %s", why);
        timed_out = 1'b1;
    endtask

    task automatic wait_flag(input logic value, input int limit);
        int n;
        n = 0;
        while (m_vbl !== value && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (m_vbl !== value)
            report_timeout("the vblank flag");
    endtask

    task automatic wait_strobe(input bit write, input int limit);
        int n;
        n = 0;
        while ((write ? vram_bus.we_n : vram_bus.rd_n) !== 1'b0 && n < limit)
        begin
            next_cycle();
            n++;
        end
        if ((write ? vram_bus.we_n : vram_bus.rd_n) !== 1'b0)
            report_timeout(write ? "a VRAM write strobe" : "a VRAM read strobe");
    endtask

    task automatic begin_test();
        test_start_errors = flow_errors + mon_errors;
    endtask

    task automatic finish_test(input string name);
        int found;
        found = flow_errors + mon_errors - test_start_errors;
        tests_run++;
        if (found == 0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, found);
        end
    endtask

    task automatic run_tests();
        logic [7:0]  d;
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [4:0]  idx;
        logic [15:0] addr;
        logic [15:0] step;
        logic [13:0] prev;
        int          n;

        begin_test();
        pause(2 * FRAME);
        if (!value_ok("o_video.x", 16'(video.x), 16'h0))
            flow_errors++;
        if (!value_ok("o_video.y", 16'(video.y), 16'h0))
            flow_errors++;
        finish_test("raster over two frames");

        begin_test();
        cpu_write(ppu_pkg::RS_PPUCTRL, 8'h80);      // interrupt follows the flag
        wait_flag(1'b1, FRAME + 8);
        if (timed_out)
            return;
        cpu_write(ppu_pkg::RS_PPUADDR, 8'h12);      // leaves the toggle set
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        if (!value_ok("status bit 7", 16'(d[7]), 16'h1))
            flow_errors++;
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        if (!value_ok("status bit 7", 16'(d[7]), 16'h0))
            flow_errors++;
        cpu_write(ppu_pkg::RS_PPUADDR, 8'h21);
        cpu_write(ppu_pkg::RS_PPUADDR, 8'h05);
        cpu_write(ppu_pkg::RS_PPUDATA, 8'h5a);
        wait_strobe(1'b1, 8);
        if (timed_out)
            return;
        if (!value_ok("o_vram.addr", 16'(vram_bus.addr), 16'h2105))
            flow_errors++;
        pause(3);
        wait_flag(1'b1, FRAME + 8);
        if (timed_out)
            return;
        wait_flag(1'b0, FRAME + 8);                 // falls at the last line
        if (timed_out)
            return;
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        if (!value_ok("status bit 7", 16'(d[7]), 16'h0))
            flow_errors++;
        finish_test("vblank flag and status read");

        begin_test();
        wait_flag(1'b1, FRAME + 8);
        if (timed_out)
            return;
        repeat (16)
        begin
            d = 8'(random_bits(8));
            cpu_write(ppu_pkg::RS_PPUCTRL, d);
            @(negedge clk);
            if (!value_ok("o_int_n", 16'(int_n), 16'(!d[7])))
                flow_errors++;
            pause(1 + int'(random_bits(2)));
        end
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        finish_test("interrupt follows ctrl bit 7");

        begin_test();
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);         // toggle back to the high byte
        repeat (12)
        begin
            step = (random_bits(1) != 0) ? 16'd32 : 16'd1;
            cpu_write(ppu_pkg::RS_PPUCTRL, (step == 16'd32) ? 8'h04 : 8'h00);
            hi   = 8'(random_bits(6) % 62);         // stays clear of the palette
            lo   = 8'(random_bits(8));
            addr = {hi, lo};
            cpu_write(ppu_pkg::RS_PPUADDR, hi);
            cpu_write(ppu_pkg::RS_PPUADDR, lo);
            n = 1 + int'(random_bits(2));
            repeat (n)
            begin
                d = 8'(random_bits(8));
                cpu_write(ppu_pkg::RS_PPUDATA, d);
                wait_strobe(1'b1, 8);
                if (timed_out)
                    return;
                if (!value_ok("o_vram.addr", 16'(vram_bus.addr), 16'(addr[13:0])))
                    flow_errors++;
                if (!value_ok("o_vram.data", 16'(vram_bus.data), 16'(d)))
                    flow_errors++;
                addr = addr + step;
                pause(3 + int'(random_bits(2)));
            end
        end
        finish_test("VRAM writes and address step");

        begin_test();
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        step = (random_bits(1) != 0) ? 16'd32 : 16'd1;
        cpu_write(ppu_pkg::RS_PPUCTRL, (step == 16'd32) ? 8'h04 : 8'h00);
        addr = {8'(random_bits(6) % 62), 8'(random_bits(8))};
        cpu_write(ppu_pkg::RS_PPUADDR, addr[15:8]);
        cpu_write(ppu_pkg::RS_PPUADDR, addr[7:0]);
        prev = '0;
        for (int k = 0; k < 8; k++)
        begin
            cpu_read(ppu_pkg::RS_PPUDATA, d);
            wait_strobe(1'b0, 8);
            if (timed_out)
                return;
            if (k > 0 && !value_ok("buffered read", 16'(d), 16'(m_vram[prev])))
                flow_errors++;
            prev = addr[13:0];
            addr = addr + step;
            pause(3 + int'(random_bits(2)));
        end
        finish_test("buffered VRAM reads");

        begin_test();
        cpu_read(ppu_pkg::RS_PPUSTATUS, d);
        repeat (8)
        begin
            idx = 5'(random_bits(5));
            d   = 8'(random_bits(8));
            cpu_write(ppu_pkg::RS_PPUADDR, 8'h3f);
            cpu_write(ppu_pkg::RS_PPUADDR, {3'(random_bits(3)), idx});
            cpu_write(ppu_pkg::RS_PPUDATA, d);
            repeat (4)
            begin
                if (!value_ok("o_vram.we_n", 16'(vram_bus.we_n), 16'h1))
                    flow_errors++;
                next_cycle();
            end
            cpu_write(ppu_pkg::RS_PPUADDR, 8'h3f);
            cpu_write(ppu_pkg::RS_PPUADDR, {3'(random_bits(3)), idx});  // same entry via a mirror
            cpu_read(ppu_pkg::RS_PPUDATA, lo);
            if (!value_ok("palette read", 16'(lo), 16'(d)))
                flow_errors++;
            pause(3);
        end
        finish_test("palette writes and reads");
    endtask

    initial
    begin
        reset_n = 1'b0;
        cpu     = {1'b1, 1'b0, ppu_pkg::RS_PPUCTRL, 8'h00};
        repeat (5) @(posedge clk);
        #1;
        reset_n  = 1'b1;
        checking = 1'b1;

        run_tests();

        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 tests_run, tests_failed, flow_errors + mon_errors);
        if (!timed_out && tests_failed == 0 && flow_errors + mon_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
